// File: common/fpPkg.sv
package fpPkg;

	// single precision field widths
	localparam int SGL_EXP_W = 8;
	localparam int SGL_MAN_W = 23;	// stored bits, hidden bit excluded

	// double precision field widths
	localparam int DBL_EXP_W = 11;
	localparam int DBL_MAN_W = 52;	// stored bits, hidden bit excluded

	// exponent biases
	localparam int SGL_BIAS = 127;
	localparam int DBL_BIAS = 1023;

	// rebias step between the formats, 1023-127
	localparam int BIAS_DIFF = DBL_BIAS - SGL_BIAS;

	// all-ones exponents mark infinity and nan
	localparam int SGL_EXP_MAX = (1 << SGL_EXP_W) - 1;
	localparam int DBL_EXP_MAX = (1 << DBL_EXP_W) - 1;

	// one 64 bit word, read either as a double or as a single in the low half
	// the converters build their results through the same view
	typedef union packed {
		struct packed {
			logic sgn;
			logic [DBL_EXP_W-1:0] exp;
			logic [DBL_MAN_W-1:0] man;
		} dbl;
		struct packed {
			logic [31:0] pad;	// upper half, zero for single results
			logic sgn;
			logic [SGL_EXP_W-1:0] exp;
			logic [SGL_MAN_W-1:0] man;
		} sgl;
	} fpWord;

endpackage

// File: common/fpFieldsIf.sv
// decomposed fields of one float, sized per format
interface fpFieldsIf #(
	parameter int EXP_W = fpPkg::SGL_EXP_W,
	parameter int MAN_W = fpPkg::SGL_MAN_W
) ();

	logic sgn;	// sign
	logic [EXP_W-1:0] exp;	// biased exponent as stored
	logic [MAN_W:0] man;	// mantissa, hidden bit restored on top
	logic xinf;	// exponent all ones, inf or nan
	logic xz;	// exponent zero, denormal or zero
	logic vz;	// whole value zero

	// decomposer side
	modport src (output sgn, exp, man, xinf, xz, vz);

	// converter side
	modport dst (input sgn, exp, man, xinf, xz, vz);

endinterface

// File: rtl/fpDecomp.sv
// splits a single or double into its fields and class flags
module fpDecomp #(
	parameter int W = 32	// 32 or 64
) (
	input logic [W-1:0] i,
	fpFieldsIf.src f
);
	import fpPkg::*;

	localparam int EXP_W = (W == 64) ? DBL_EXP_W : SGL_EXP_W;
	localparam int MAN_W = (W == 64) ? DBL_MAN_W : SGL_MAN_W;

	logic [EXP_W-1:0] expF;	// raw exponent field
	logic [MAN_W-1:0] manF;	// raw mantissa field
	logic expOnes;
	logic expZero;

	assign expF = i[W-2 -: EXP_W];
	assign manF = i[MAN_W-1:0];

	assign expOnes = &expF;
	assign expZero = ~|expF;

	assign f.sgn = i[W-1];
	assign f.exp = expF;

	// hidden one only for normals
	// denormals keep a zero on top
	assign f.man = {~expZero, manF};

	assign f.xinf = expOnes;
	assign f.xz = expZero;
	assign f.vz = expZero & ~|manF;	// +0 or -0

endmodule

// File: rtl/cntlz24.sv
// leading zero count over a 24 bit mantissa, 24 when all zero
module cntlz24 (
	input logic [23:0] i,
	output logic [4:0] lz
);

	// leading zeros of one byte, 8 for an empty byte
	function automatic logic [3:0] lzByte(input logic [7:0] b);
		logic [3:0] n;
		n = 4'd8;
		for (int k = 0; k < 8; k++) begin
			if (b[k])
				n = 4'(7 - k);	// highest set bit wins, loop runs upward
		end
		return n;
	endfunction

	logic [7:0] hiB, midB, loB;

	assign hiB = i[23:16];
	assign midB = i[15:8];
	assign loB = i[7:0];

	// pick the first nonempty byte from the top
	always_comb begin
		if (|hiB)
			lz = 5'(lzByte(hiB));
		else if (|midB)
			lz = 5'd8 + 5'(lzByte(midB));
		else
			lz = 5'd16 + 5'(lzByte(loB));	// empty low byte gives 24
	end

endmodule

// File: convert/fs2d.sv
// single to double conversion, exact in every case
module fs2d (
	input fpPkg::fpWord a,
	output fpPkg::fpWord o
);
	import fpPkg::*;

	localparam int PAD_W = DBL_MAN_W - SGL_MAN_W;	// 29 low mantissa bits gained

	fpFieldsIf #(.EXP_W(SGL_EXP_W), .MAN_W(SGL_MAN_W)) sf ();

	logic [4:0] lz;	// leading zeros of the 24 bit mantissa
	logic [SGL_MAN_W-1:0] denMan;	// denormal fraction after renormalizing
	logic [DBL_EXP_W-1:0] denExp;

	fpDecomp #(.W(32)) uDecomp (
		.i({a.sgl.sgn, a.sgl.exp, a.sgl.man}),
		.f(sf)
	);

	// hidden bit is zero for a denormal, so lz is at least one there
	cntlz24 uLz (
		.i(sf.man),
		.lz(lz)
	);

	// shift past the leading one so it becomes the new hidden bit
	assign denMan = sf.man[SGL_MAN_W-1:0] << (lz + 5'd1);

	// single denormals sit at 2^-126, well inside double range
	assign denExp = DBL_EXP_W'(BIAS_DIFF + 1) - DBL_EXP_W'(lz);	// 897 - lz

	always_comb begin
		o = '0;
		o.dbl.sgn = sf.sgn;	// sign always passes
		if (sf.vz) begin
			o.dbl.exp = '0;	// signed zero
			o.dbl.man = '0;
		end
		else if (sf.xinf) begin
			o.dbl.exp = DBL_EXP_W'(DBL_EXP_MAX);
			o.dbl.man = {sf.man[SGL_MAN_W-1:0], {PAD_W{1'b0}}};	// nan payload kept
		end
		else if (sf.xz) begin
			o.dbl.exp = denExp;
			o.dbl.man = {denMan, {PAD_W{1'b0}}};
		end
		else begin
			// plain rebias, mantissa widened
			o.dbl.exp = DBL_EXP_W'(sf.exp) + DBL_EXP_W'(BIAS_DIFF);
			o.dbl.man = {sf.man[SGL_MAN_W-1:0], {PAD_W{1'b0}}};
		end
	end

endmodule

// File: convert/fd2s.sv
// double to single conversion, round to nearest even
module fd2s (
	input fpPkg::fpWord a,
	output fpPkg::fpWord o
);
	import fpPkg::*;

	localparam int GUARD_W = 32;	// extra low bits that catch a denormal shift
	localparam int WIDE_W = DBL_MAN_W + 1 + GUARD_W;	// 85
	localparam int KEEP_W = SGL_MAN_W + 1;	// kept bits incl hidden
	localparam int G_POS = WIDE_W - KEEP_W - 1;	// guard bit index
	localparam int DIF_W = SGL_MAN_W;	// top stored bits that carry over on nan

	fpFieldsIf #(.EXP_W(DBL_EXP_W), .MAN_W(DBL_MAN_W)) df ();

	logic [12:0] expEff;	// double exponent, denormals at 1
	logic [12:0] e;	// rebiased to single, wraps negative
	logic isDen;	// result below smallest single normal
	logic [12:0] shFull;
	logic [4:0] shAmt;	// capped right shift for denormal results
	logic [WIDE_W-1:0] wide;
	logic [KEEP_W-1:0] kept;
	logic g, r, s;	// guard, round, sticky
	logic roundUp;
	logic [KEEP_W:0] rounded;	// one spare bit for the carry
	logic [12:0] expBase;
	logic [12:0] expFinal;
	logic ovf;
	logic isNan;
	logic [SGL_MAN_W-1:0] nanMan;

	fpDecomp #(.W(64)) uDecomp (
		.i(a.dbl),
		.f(df)
	);

	assign expEff = df.xz ? 13'd1 : 13'(df.exp);
	assign e = expEff - 13'(BIAS_DIFF);
	assign isDen = e[12] | (e == 13'd0);	// e <= 0

	// shift so the value lands at single exponent 1
	assign shFull = 13'd1 - e;
	always_comb begin
		if (!isDen)
			shAmt = 5'd0;
		else if (shFull > 13'd31)
			shAmt = 5'd31;	// everything already in sticky
		else
			shAmt = shFull[4:0];
	end

	// normal results discard the low 29 bits, denormals lose more
	assign wide = {df.man, {GUARD_W{1'b0}}} >> shAmt;
	assign kept = wide[WIDE_W-1 -: KEEP_W];
	assign g = wide[G_POS];
	assign r = wide[G_POS-1];
	assign s = |wide[G_POS-2:0];

	// ties go to the even neighbour
	assign roundUp = g & (r | s | kept[0]);
	assign rounded = {1'b0, kept} + (KEEP_W+1)'(roundUp);

	// the top two rounded bits add the exponent back
	// 01 normal, 10 mantissa carry, 01 from a denormal that rounded up to normal
	assign expBase = isDen ? 13'd0 : e - 13'd1;
	assign expFinal = expBase + 13'(rounded[KEEP_W:KEEP_W-1]);
	assign ovf = ~isDen & (expFinal >= 13'(SGL_EXP_MAX));	// above 2^127

	// nan keeps its top payload bits, still a nan if those are zero
	assign isNan = df.xinf & |df.man[DBL_MAN_W-1:0];
	assign nanMan = df.man[DBL_MAN_W-1 -: DIF_W]
		| {~|df.man[DBL_MAN_W-1 -: DIF_W], {(DIF_W-1){1'b0}}};

	always_comb begin
		o = '0;	// upper half stays zero
		o.sgl.sgn = df.sgn;
		if (isNan) begin
			o.sgl.exp = SGL_EXP_W'(SGL_EXP_MAX);
			o.sgl.man = nanMan;
		end
		else if (df.xinf || ovf) begin
			o.sgl.exp = SGL_EXP_W'(SGL_EXP_MAX);	// infinity
			o.sgl.man = '0;
		end
		else if (df.vz) begin
			o.sgl.exp = '0;	// signed zero
			o.sgl.man = '0;
		end
		else begin
			o.sgl.exp = expFinal[SGL_EXP_W-1:0];
			o.sgl.man = rounded[SGL_MAN_W-1:0];	// zero after a carry
		end
	end

endmodule

// File: rtl/fpConvert.sv
// float format converter, single<->double, one clock latency
module fpConvert (
	input logic clk,
	input logic arstN,
	input logic ld,	// load strobe
	input logic dir,	// 0 single to double, 1 double to single
	input logic [63:0] a,
	output logic [63:0] o,
	output logic done	// one cycle after each ld
);
	import fpPkg::*;

	fpWord opnd;	// operand seen as either format
	fpWord sdRes;	// single to double result
	fpWord dsRes;	// double to single result
	fpWord res;

	assign opnd = a;

	// both converters run on every operand
	fs2d uS2d (
		.a(opnd),
		.o(sdRes)
	);

	fd2s uD2s (
		.a(opnd),
		.o(dsRes)
	);

	// fd2s already clears the upper half
	assign res = dir ? dsRes : sdRes;

	// result register, held between loads
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			o <= '0;
		end
		else if (ld) begin
			o <= res;
		end
	end

	// done follows ld by one clock
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			done <= 1'b0;
		else
			done <= ld;
	end

endmodule

// File: sim/fpVectors.svh
// columns: addVec(test name, dir, operand a, expected o)
// dir 0 takes the single in a[31:0], dir 1 returns the single in o[31:0]
`ifndef FP_VECTORS_SVH
`define FP_VECTORS_SVH

task automatic buildTable();
	// single to double
	addVec("s2d +zero", 1'b0, 64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000);
	addVec("s2d -zero", 1'b0, 64'h0000_0000_8000_0000, 64'h8000_0000_0000_0000);
	addVec("s2d one", 1'b0, 64'h0000_0000_3F80_0000, 64'h3FF0_0000_0000_0000);
	addVec("s2d one hi junk", 1'b0, 64'hDEAD_BEEF_3F80_0000, 64'h3FF0_0000_0000_0000);
	addVec("s2d -2.5", 1'b0, 64'h0000_0000_C020_0000, 64'hC004_0000_0000_0000);
	addVec("s2d max normal", 1'b0, 64'h0000_0000_7F7F_FFFF, 64'h47EF_FFFF_E000_0000);
	addVec("s2d min normal", 1'b0, 64'h0000_0000_0080_0000, 64'h3810_0000_0000_0000);
	addVec("s2d +inf", 1'b0, 64'h0000_0000_7F80_0000, 64'h7FF0_0000_0000_0000);
	addVec("s2d -inf", 1'b0, 64'h0000_0000_FF80_0000, 64'hFFF0_0000_0000_0000);
	addVec("s2d qnan", 1'b0, 64'h0000_0000_7FC0_0000, 64'h7FF8_0000_0000_0000);
	addVec("s2d snan", 1'b0, 64'h0000_0000_7F80_0001, 64'h7FF0_0000_2000_0000);
	addVec("s2d den lz1", 1'b0, 64'h0000_0000_0040_0000, 64'h3800_0000_0000_0000);
	addVec("s2d den lz7 neg", 1'b0, 64'h0000_0000_8001_0000, 64'hB7A0_0000_0000_0000);
	addVec("s2d den lz15", 1'b0, 64'h0000_0000_0000_0100, 64'h3720_0000_0000_0000);
	addVec("s2d den min", 1'b0, 64'h0000_0000_0000_0001, 64'h36A0_0000_0000_0000);	// lz 23

	// double to single, exact and rounded
	addVec("d2s one", 1'b1, 64'h3FF0_0000_0000_0000, 64'h0000_0000_3F80_0000);
	addVec("d2s -2.5", 1'b1, 64'hC004_0000_0000_0000, 64'h0000_0000_C020_0000);
	addVec("d2s -zero", 1'b1, 64'h8000_0000_0000_0000, 64'h0000_0000_8000_0000);
	addVec("d2s tie down", 1'b1, 64'h3FF0_0000_1000_0000, 64'h0000_0000_3F80_0000);
	addVec("d2s tie up", 1'b1, 64'h3FF0_0000_3000_0000, 64'h0000_0000_3F80_0002);
	addVec("d2s above tie", 1'b1, 64'h3FF0_0000_1000_0001, 64'h0000_0000_3F80_0001);
	addVec("d2s below tie", 1'b1, 64'h3FF0_0000_0FFF_FFFF, 64'h0000_0000_3F80_0000);
	addVec("d2s carry", 1'b1, 64'h3FFF_FFFF_F000_0000, 64'h0000_0000_4000_0000);	// to 2.0

	// double to single, range limits
	addVec("d2s overflow", 1'b1, 64'h47F0_0000_0000_0000, 64'h0000_0000_7F80_0000);
	addVec("d2s -overflow", 1'b1, 64'hC7F0_0000_0000_0000, 64'h0000_0000_FF80_0000);
	addVec("d2s round ovf", 1'b1, 64'h47EF_FFFF_F000_0000, 64'h0000_0000_7F80_0000);
	addVec("d2s max single", 1'b1, 64'h47EF_FFFF_E000_0000, 64'h0000_0000_7F7F_FFFF);
	addVec("d2s den tie even", 1'b1, 64'h3800_0000_2000_0000, 64'h0000_0000_0040_0000);
	addVec("d2s den round up", 1'b1, 64'h3800_0000_6000_0000, 64'h0000_0000_0040_0002);
	addVec("d2s den to normal", 1'b1, 64'h380F_FFFF_F000_0000, 64'h0000_0000_0080_0000);
	addVec("d2s min den", 1'b1, 64'h36A0_0000_0000_0000, 64'h0000_0000_0000_0001);
	addVec("d2s min den up", 1'b1, 64'h3698_0000_0000_0000, 64'h0000_0000_0000_0001);
	addVec("d2s half min den", 1'b1, 64'h3690_0000_0000_0000, 64'h0000_0000_0000_0000);
	addVec("d2s flush -zero", 1'b1, 64'hB370_0000_0000_0000, 64'h0000_0000_8000_0000);
	addVec("d2s dbl denormal", 1'b1, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0000);
	addVec("d2s nan low bits", 1'b1, 64'h7FF0_0000_0000_0001, 64'h0000_0000_7FC0_0000);
	addVec("d2s nan payload", 1'b1, 64'h7FF0_0000_2000_0000, 64'h0000_0000_7F80_0001);
	addVec("d2s -qnan", 1'b1, 64'hFFF8_0000_0000_0000, 64'h0000_0000_FFC0_0000);
	addVec("d2s +inf", 1'b1, 64'h7FF0_0000_0000_0000, 64'h0000_0000_7F80_0000);
	addVec("d2s -inf", 1'b1, 64'hFFF0_0000_0000_0000, 64'h0000_0000_FF80_0000);
endtask

`endif

// File: sim/fpConvertTb.sv
// testbench for fpConvert, directed table then random singles then a back to back stream
module fpConvertTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk;
	logic arstN;
	logic ld;
	logic dir;
	logic [63:0] a;
	logic [63:0] o;
	logic done;

	// directed table, filled by buildTable
	string names[$];
	logic tDir[$];
	logic [63:0] tIn[$];
	logic [63:0] tExp[$];

	fpConvert DUT (
		.clk(clk),
		.arstN(arstN),
		.ld(ld),
		.dir(dir),
		.a(a),
		.o(o),
		.done(done)
	);

	task automatic addVec(input string n, input logic d, input logic [63:0] i,
		input logic [63:0] e);
		names.push_back(n);
		tDir.push_back(d);
		tIn.push_back(i);
		tExp.push_back(e);
	endtask

	`include "fpVectors.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	// normal single to double: rebias by 896, mantissa padded with 29 zeros
	function automatic logic [63:0] widenNormal(input logic [31:0] s);
		logic [10:0] e;
		e = 11'(s[30:23]) + 11'd896;
		return {s[31], e, s[22:0], 29'b0};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// one load, then wait for done, then one idle cycle
	task automatic applyOp(input string name, input logic d, input logic [63:0] val,
		input logic [63:0] expected);
		int waited;
		waited = 0;
		ld = 1'b1;
		dir = d;
		a = val;
		@(posedge clk);
		#5;
		ld = 1'b0;
		a = ~val;	// o must not follow a without ld
		while (!done) begin
			@(posedge clk);
			#5;
			waited++;
		end
		checkValue({name, " latency"}, 64'd0, 64'(waited));
		checkValue(name, expected, o);
		@(posedge clk);
		#5;
		checkValue({name, " done pulse"}, 64'd0, 64'(done));
		checkValue({name, " hold"}, expected, o);
	endtask

	task automatic resetPhase();
		// loads requested during reset must be ignored
		ld = 1'b1;
		a = 64'h0000_0000_3F80_0000;
		repeat (3) begin
			@(posedge clk);
			#5;
			checkValue("reset o", 64'd0, o);
			checkValue("reset done", 64'd0, 64'(done));
		end
		arstN = 1'b1;
		ld = 1'b0;
		a = '0;
		@(posedge clk);
		#5;
		checkValue("after reset o", 64'd0, o);
		checkValue("after reset done", 64'd0, 64'(done));
	endtask

	task automatic runRandom();
		logic [31:0] rnd;
		logic [7:0] ex;
		logic [31:0] sngl;
		for (int k = 0; k < 200; k++) begin
			rnd = $urandom;
			ex = 8'(1 + (rnd[30:23] % 254));	// 1..254, normals only
			sngl = {rnd[31], ex, rnd[22:0]};
			applyOp($sformatf("random %0d", k), 1'b0, {32'h0, sngl}, widenNormal(sngl));
		end
	endtask

	// strobe every cycle, dir alternating, each double goes straight back
	task automatic runThroughput();
		logic [31:0] singles [3];
		logic opDir [6];
		logic [63:0] opIn [6];
		logic [63:0] opExp [6];
		singles = '{32'h4049_0FDB, 32'hC2F6_E979, 32'h3E80_0000};
		for (int k = 0; k < 3; k++) begin
			opDir[2*k] = 1'b0;
			opIn[2*k] = {32'h0, singles[k]};
			opExp[2*k] = widenNormal(singles[k]);
			opDir[2*k+1] = 1'b1;
			opIn[2*k+1] = widenNormal(singles[k]);	// exact, comes back unchanged
			opExp[2*k+1] = {32'h0, singles[k]};
		end
		ld = 1'b1;
		dir = opDir[0];
		a = opIn[0];
		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			#5;
			checkValue($sformatf("stream %0d done", k), 64'd1, 64'(done));
			checkValue($sformatf("stream %0d", k), opExp[k], o);
			if (k < 5) begin
				dir = opDir[k+1];
				a = opIn[k+1];
			end
			else begin
				ld = 1'b0;
			end
		end
		a = 64'h0123_4567_89AB_CDEF;	// inputs wander, o stays
		dir = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#5;
			checkValue("stream idle done", 64'd0, 64'(done));
			checkValue("stream idle hold", opExp[5], o);
		end
	endtask

	initial begin
		int seedInit;
		seedInit = $urandom(32'h4f5c_55da);
		arstN = 1'b0;
		ld = 1'b0;
		dir = 1'b0;
		a = '0;
		buildTable();
		resetPhase();
		for (int i = 0; i < names.size(); i++)
			applyOp(names[i], tDir[i], tIn[i], tExp[i]);
		runRandom();
		runThroughput();
		$display("Regression passed");
		$finish;
	end

	// two cycles per operation plus slack for reset and the stream
	initial begin
		longint limitNs;
		#1;
		limitNs = (longint'(names.size()) + 200 + 10) * 2 * 100;
		#(limitNs);
		$display("Timeout: the run did not finish within %0d ns", limitNs);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: all.f
+incdir+sim
common/fpPkg.sv
common/fpFieldsIf.sv
rtl/fpDecomp.sv
rtl/cntlz24.sv
convert/fs2d.sv
convert/fd2s.sv
rtl/fpConvert.sv
sim/fpConvertTb.sv

// File: run.sh
#!/bin/sh
# build and run the fpConvert testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module fpConvertTb -f all.f -o fpConvertSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/fpConvertSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

exit 0
